// File: hdl/lcCtrlPkg.sv
package lcCtrlPkg;

  // --------------------
  // Life cycle encoding
  // --------------------

  // States are listed in the order of the device life
  // A plain magnitude compare therefore tells whether a target lies later than the present state
  typedef enum logic [3:0] {
    Raw           = 4'd0,
    TestUnlocked0 = 4'd1,
    TestLocked0   = 4'd2,
    TestUnlocked1 = 4'd3,
    TestLocked1   = 4'd4,
    TestUnlocked2 = 4'd5,
    TestLocked2   = 4'd6,
    TestUnlocked3 = 4'd7,
    Dev           = 4'd8,
    Prod          = 4'd9,
    ProdEnd       = 4'd10,
    Rma           = 4'd11,
    Scrap         = 4'd12
  } lcState;

  // Transition counter, saturating at its top value
  localparam int LcCntWidth = 4;
  localparam logic [LcCntWidth-1:0] LcCntMax = LcCntWidth'(15);

  // --------------------
  // Controller FSM
  // --------------------

  typedef enum logic [2:0] {
    Idle,
    CntIncr,
    CntProg,
    TransCheck,
    TokenCheck,
    TransProg,
    PostTrans
  } fsmState;

  // Result code reported at the end of every request
  typedef enum logic [1:0] {
    ErrNone,
    ErrCntOverflow,
    ErrTransInvalid,
    ErrToken
  } lcErr;

  // Length of one programming pass in clock cycles
  localparam int ProgCycles = 4;
  localparam int ProgCntWidth = $clog2(ProgCycles + 1);
  localparam logic [ProgCntWidth-1:0] ProgLoad = ProgCntWidth'(ProgCycles);

  // --------------------
  // Unlock tokens
  // --------------------

  // Token class that a transition asks for
  typedef enum logic [1:0] {
    TokNone,
    TokRawUnlock,
    TokTestUnlock,
    TokRma
  } tokenKind;

  localparam int TokenWidth = 32;
  // Plain constants stand in for the provisioned secrets
  localparam logic [TokenWidth-1:0] RawUnlockToken  = 32'h5a3c_96e1;
  localparam logic [TokenWidth-1:0] TestUnlockToken = 32'hc0de_7e57;
  localparam logic [TokenWidth-1:0] RmaToken        = 32'h2b9d_f40a;

endpackage

// File: hdl/lcStateTransition.sv
module lcStateTransition (
  input  lcCtrlPkg::lcState                  lcState_i,
  input  logic [lcCtrlPkg::LcCntWidth-1:0]   lcCnt_i,
  input  lcCtrlPkg::lcState                  transTarget_i,
  output lcCtrlPkg::lcState                  nextState_o,
  output logic [lcCtrlPkg::LcCntWidth-1:0]   nextCnt_o,
  output logic                               cntOverflow_o,
  output logic                               transInvalid_o,
  output lcCtrlPkg::tokenKind                needToken_o
);

  // Set when the requested edge is part of the transition graph
  logic legal;

  always_comb begin
    // Hold the present values unless a rule below says otherwise
    nextState_o    = lcState_i;
    nextCnt_o      = lcCnt_i;
    cntOverflow_o  = 1'b0;
    transInvalid_o = 1'b0;
    needToken_o    = lcCtrlPkg::TokNone;
    legal          = 1'b0;

    // --------------------
    // Counter increment
    // --------------------

    // A counter at its top value cannot take another transition
    if (lcCnt_i == lcCtrlPkg::LcCntMax) begin
      cntOverflow_o = 1'b1;
    end else begin
      nextCnt_o = lcCnt_i + 1'b1;
    end

    // --------------------
    // Legality and tokens
    // --------------------

    if (transTarget_i == lcCtrlPkg::Scrap) begin
      // Scrap is always reachable, even with an exhausted counter
      // The counter is pinned to its top so the device cannot transition again
      nextCnt_o     = lcCtrlPkg::LcCntMax;
      nextState_o   = lcCtrlPkg::Scrap;
      cntOverflow_o = 1'b0;
    end else begin
      if (transTarget_i > lcCtrlPkg::Scrap) begin
        // Encodings past Scrap are not life cycle states
        legal = 1'b0;
      end else if (lcState_i == lcCtrlPkg::Raw) begin
        // A blank device can only be opened for test
        legal = (transTarget_i == lcCtrlPkg::TestUnlocked0);
      end else if (lcState_i inside {lcCtrlPkg::ProdEnd, lcCtrlPkg::Rma, lcCtrlPkg::Scrap}) begin
        // Terminal states only lead to Scrap, which is handled above
        legal = 1'b0;
      end else if (lcState_i == lcCtrlPkg::Prod && transTarget_i == lcCtrlPkg::Dev) begin
        // Prod never goes back to Dev
        legal = 1'b0;
      end else begin
        // Everything else must move strictly forward
        legal = (transTarget_i > lcState_i);
      end

      if (legal) begin
        nextState_o = transTarget_i;
        // Pick the token class the edge has to present
        if (lcState_i == lcCtrlPkg::Raw) begin
          needToken_o = lcCtrlPkg::TokRawUnlock;
        end else if (transTarget_i inside {lcCtrlPkg::TestUnlocked0, lcCtrlPkg::TestUnlocked1,
                                           lcCtrlPkg::TestUnlocked2, lcCtrlPkg::TestUnlocked3})
        begin
          needToken_o = lcCtrlPkg::TokTestUnlock;
        end else if (transTarget_i == lcCtrlPkg::Rma) begin
          needToken_o = lcCtrlPkg::TokRma;
        end
      end else begin
        transInvalid_o = 1'b1;
      end
    end
  end

endmodule

// File: hdl/lcCtrlFsm.sv
module lcCtrlFsm (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 transCmd_i,
  input  lcCtrlPkg::lcState    transTarget_i,
  input  logic                 cntOverflow_i,
  input  logic                 transInvalid_i,
  input  logic                 tokenOk_i,
  input  logic                 timerDone_i,
  output lcCtrlPkg::lcState    target_o,
  output logic                 tokenCapture_o,
  output logic                 timerStart_o,
  output logic                 cntWrite_o,
  output logic                 stateWrite_o,
  output logic                 busy_o,
  output logic                 done_o,
  output lcCtrlPkg::lcErr      error_o
);

  // Sequence of a successful request, counting the edge that accepts the strobe as edge 0
  // CntIncr at edge 1, CntProg for ProgCycles edges, TransCheck, TokenCheck,
  // TransProg for ProgCycles edges, then PostTrans at edge 2*ProgCycles+4
  // The whole request thus spans 2*ProgCycles+5 cycles including the strobe cycle

  lcCtrlPkg::fsmState stateQ;
  lcCtrlPkg::fsmState stateD;
  lcCtrlPkg::lcErr    errorQ;
  lcCtrlPkg::lcErr    errorD;
  lcCtrlPkg::lcState  targetQ;

  // --------------------
  // Next state logic
  // --------------------

  always_comb begin
    stateD         = stateQ;
    errorD         = errorQ;
    tokenCapture_o = 1'b0;
    timerStart_o   = 1'b0;
    cntWrite_o     = 1'b0;
    stateWrite_o   = 1'b0;

    case (stateQ)
      lcCtrlPkg::Idle: begin
        // Accept a request and clear the result of the previous one
        if (transCmd_i) begin
          tokenCapture_o = 1'b1;
          errorD         = lcCtrlPkg::ErrNone;
          stateD         = lcCtrlPkg::CntIncr;
        end
      end
      lcCtrlPkg::CntIncr: begin
        // The counter is bumped before anything else so that every attempt costs one count
        if (cntOverflow_i) begin
          errorD = lcCtrlPkg::ErrCntOverflow;
          stateD = lcCtrlPkg::PostTrans;
        end else begin
          cntWrite_o   = 1'b1;
          timerStart_o = 1'b1;
          stateD       = lcCtrlPkg::CntProg;
        end
      end
      lcCtrlPkg::CntProg: begin
        // Wait out the first programming pass
        if (timerDone_i) begin
          stateD = lcCtrlPkg::TransCheck;
        end
      end
      lcCtrlPkg::TransCheck: begin
        if (transInvalid_i) begin
          errorD = lcCtrlPkg::ErrTransInvalid;
          stateD = lcCtrlPkg::PostTrans;
        end else begin
          stateD = lcCtrlPkg::TokenCheck;
        end
      end
      lcCtrlPkg::TokenCheck: begin
        // A good token starts the second programming pass right away
        if (!tokenOk_i) begin
          errorD = lcCtrlPkg::ErrToken;
          stateD = lcCtrlPkg::PostTrans;
        end else begin
          timerStart_o = 1'b1;
          stateD       = lcCtrlPkg::TransProg;
        end
      end
      lcCtrlPkg::TransProg: begin
        // The new state lands in the store on the last cycle of the pass
        if (timerDone_i) begin
          stateWrite_o = 1'b1;
          stateD       = lcCtrlPkg::PostTrans;
        end
      end
      lcCtrlPkg::PostTrans: begin
        stateD = lcCtrlPkg::Idle;
      end
      default: begin
        stateD = lcCtrlPkg::Idle;
      end
    endcase
  end

  // --------------------
  // Registers
  // --------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stateQ <= lcCtrlPkg::Idle;
      errorQ <= lcCtrlPkg::ErrNone;
    end else begin
      stateQ <= stateD;
      errorQ <= errorD;
    end
  end

  // Target is held for the whole request and only loaded on acceptance
  always_ff @(posedge clk_i) begin
    if (tokenCapture_o) begin
      targetQ <= transTarget_i;
    end
  end

  assign target_o = targetQ;
  assign busy_o   = (stateQ != lcCtrlPkg::Idle) && (stateQ != lcCtrlPkg::PostTrans);
  assign done_o   = (stateQ == lcCtrlPkg::PostTrans);
  assign error_o  = errorQ;

endmodule

// File: hdl/lcProgTimer.sv
module lcProgTimer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  output logic done_o
);

  // Remaining cycles of the running pass, zero when idle
  logic [lcCtrlPkg::ProgCntWidth-1:0] cntQ;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cntQ <= '0;
    end else if (start_i) begin
      // A start while counting simply reloads the full length
      cntQ <= lcCtrlPkg::ProgLoad;
    end else if (cntQ != '0) begin
      cntQ <= cntQ - 1'b1;
    end
  end

  // The pass ends on the last count, ProgCycles cycles after the start pulse
  assign done_o = (cntQ == lcCtrlPkg::ProgCntWidth'(1));

endmodule

// File: hdl/lcStateStore.sv
module lcStateStore (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               cntWrite_i,
  input  logic                               stateWrite_i,
  input  logic [lcCtrlPkg::LcCntWidth-1:0]   nextCnt_i,
  input  lcCtrlPkg::lcState                  nextState_i,
  output lcCtrlPkg::lcState                  lcState_o,
  output logic [lcCtrlPkg::LcCntWidth-1:0]   lcCnt_o
);

  // Model of the OTP life cycle partition
  // Programming latency lives in the FSM and timer, here a write is a single load
  lcCtrlPkg::lcState                 stateQ;
  logic [lcCtrlPkg::LcCntWidth-1:0]  cntQ;

  // --------------------
  // Counter field
  // --------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cntQ <= '0;
    end else if (cntWrite_i) begin
      cntQ <= nextCnt_i;
    end
  end

  // --------------------
  // State field
  // --------------------

  // A blank device comes up in Raw
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stateQ <= lcCtrlPkg::Raw;
    end else if (stateWrite_i) begin
      stateQ <= nextState_i;
    end
  end

  assign lcState_o = stateQ;
  assign lcCnt_o   = cntQ;

endmodule

// File: hdl/lcTokenCheck.sv
module lcTokenCheck (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               capture_i,
  input  logic [lcCtrlPkg::TokenWidth-1:0]   token_i,
  input  lcCtrlPkg::tokenKind                needToken_i,
  output logic                               tokenOk_o
);

  logic [lcCtrlPkg::TokenWidth-1:0] tokenQ;
  logic [lcCtrlPkg::TokenWidth-1:0] expected;

  // The token only is valid in the strobe cycle, so it is kept for the later check
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tokenQ <= '0;
    end else if (capture_i) begin
      tokenQ <= token_i;
    end
  end

  // Reference value for the class the transition asks for
  always_comb begin
    case (needToken_i)
      lcCtrlPkg::TokRawUnlock:  expected = lcCtrlPkg::RawUnlockToken;
      lcCtrlPkg::TokTestUnlock: expected = lcCtrlPkg::TestUnlockToken;
      lcCtrlPkg::TokRma:        expected = lcCtrlPkg::RmaToken;
      default:                  expected = '0;
    endcase
  end

  // Edges without a token class pass whatever was presented
  assign tokenOk_o = (needToken_i == lcCtrlPkg::TokNone) || (tokenQ == expected);

endmodule

// File: hdl/lcCtrlTop.sv
module lcCtrlTop (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               transCmd_i,
  input  lcCtrlPkg::lcState                  transTarget_i,
  input  logic [lcCtrlPkg::TokenWidth-1:0]   transToken_i,
  output lcCtrlPkg::lcState                  lcState_o,
  output logic [lcCtrlPkg::LcCntWidth-1:0]   lcCnt_o,
  output logic                               busy_o,
  output logic                               done_o,
  output lcCtrlPkg::lcErr                    error_o
);

  // FSM control strobes
  logic tokenCapture;
  logic timerStart;
  logic timerDone;
  logic cntWrite;
  logic stateWrite;

  // Transition function results
  lcCtrlPkg::lcState                 target;
  lcCtrlPkg::lcState                 nextState;
  logic [lcCtrlPkg::LcCntWidth-1:0]  nextCnt;
  logic                              cntOverflow;
  logic                              transInvalid;
  lcCtrlPkg::tokenKind               needToken;
  logic                              tokenOk;

  // --------------------
  // Sequencing
  // --------------------

  lcCtrlFsm fsm0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .transCmd_i     (transCmd_i),
    .transTarget_i  (transTarget_i),
    .cntOverflow_i  (cntOverflow),
    .transInvalid_i (transInvalid),
    .tokenOk_i      (tokenOk),
    .timerDone_i    (timerDone),
    .target_o       (target),
    .tokenCapture_o (tokenCapture),
    .timerStart_o   (timerStart),
    .cntWrite_o     (cntWrite),
    .stateWrite_o   (stateWrite),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .error_o        (error_o)
  );

  lcProgTimer timer0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (timerStart),
    .done_o  (timerDone)
  );

  // --------------------
  // Datapath
  // --------------------

  lcStateStore store0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cntWrite_i   (cntWrite),
    .stateWrite_i (stateWrite),
    .nextCnt_i    (nextCnt),
    .nextState_i  (nextState),
    .lcState_o    (lcState_o),
    .lcCnt_o      (lcCnt_o)
  );

  // Works on the stored state and the target held by the FSM
  lcStateTransition trans0 (
    .lcState_i      (lcState_o),
    .lcCnt_i        (lcCnt_o),
    .transTarget_i  (target),
    .nextState_o    (nextState),
    .nextCnt_o      (nextCnt),
    .cntOverflow_o  (cntOverflow),
    .transInvalid_o (transInvalid),
    .needToken_o    (needToken)
  );

  lcTokenCheck token0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .capture_i   (tokenCapture),
    .token_i     (transToken_i),
    .needToken_i (needToken),
    .tokenOk_o   (tokenOk)
  );

endmodule

// File: testbench/lcCtrl_assert.sv
module lcCtrl_assert (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               transCmd_i,
  input  logic                               busy_i,
  input  logic                               done_i,
  input  lcCtrlPkg::lcErr                    error_i,
  input  lcCtrlPkg::lcState                  lcState_i,
  input  logic [lcCtrlPkg::LcCntWidth-1:0]   lcCnt_i,
  input  lcCtrlPkg::fsmState                 fsmState_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Sampled distance from an accepted strobe to done_o of a clean request
  // Strobe at edge 0, PostTrans entered at edge 2*ProgCycles+3, seen at the next edge
  localparam int SuccessLatency = 2 * lcCtrlPkg::ProgCycles + 4;

  // Failures seen so far, read by the testbench for its closing line
  int unsigned failCount = 0;

  // The FSM only takes a strobe while it sits in Idle
  logic accept;
  assign accept = transCmd_i && (fsmState_i == lcCtrlPkg::Idle);

  // --------------------
  // Handshake
  // --------------------

  resetQuiet: assert property (@(posedge clk_i) rst_i |=> !busy_i && !done_i)
    else begin
      $error("busy_o or done_o high in the cycle after reset");
      failCount++;
    end

  doneSingle: assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
    else begin
      $error("done_o held for more than one cycle");
      failCount++;
    end

  doneAfterBusy: assert property (@(posedge clk_i) disable iff (rst_i) done_i |-> $past(busy_i))
    else begin
      $error("done_o without a busy cycle before it");
      failCount++;
    end

  // --------------------
  // Stored fields
  // --------------------

  // The state field is only loaded at the end of the second programming pass
  stateWriteTime: assert property (@(posedge clk_i) disable iff (rst_i)
      (lcState_i != $past(lcState_i)) |->
      ($past(fsmState_i) == lcCtrlPkg::TransProg) && (fsmState_i == lcCtrlPkg::PostTrans))
    else begin
      $error("lcState_o changed outside the end of TransProg");
      failCount++;
    end

  // Counter moves by one per attempt, or jumps to its top on Scrap
  cntStep: assert property (@(posedge clk_i) disable iff (rst_i)
      (lcCnt_i != $past(lcCnt_i)) |->
      (lcCnt_i == $past(lcCnt_i) + 1'b1) || (lcCnt_i == lcCtrlPkg::LcCntMax))
    else begin
      $error("lcCnt_o took a step other than +1 or saturation");
      failCount++;
    end

  // A clean request always takes the same number of cycles
  successLatency: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i && (error_i == lcCtrlPkg::ErrNone) |-> $past(accept, SuccessLatency))
    else begin
      $error("successful request finished with the wrong latency");
      failCount++;
    end

endmodule

// File: testbench/lcCtrlTb.sv
module lcCtrlTb;
  timeunit 1ns;
  timeprecision 100ps;

  // Longest request is CntIncr, two passes, two checks, PostTrans and a few idle cycles
  localparam int ResetCycles    = 16;
  localparam int ReqCycles      = 2 * lcCtrlPkg::ProgCycles + 9;
  localparam int MaxRequests    = 60;
  localparam int MaxCycles      = 3 * ResetCycles + MaxRequests * ReqCycles + 1000;
  localparam int RandomRequests = 30;
  localparam logic [31:0] Seed  = 32'hfe40_fb9c;

  logic                               clk;
  logic                               rst;
  logic                               transCmd;
  lcCtrlPkg::lcState                  transTarget;
  logic [31:0]                        transToken;
  lcCtrlPkg::lcState                  lcState;
  logic [lcCtrlPkg::LcCntWidth-1:0]   lcCnt;
  logic                               busy;
  logic                               done;
  lcCtrlPkg::lcErr                    lcError;

  // Reference model of the life cycle partition
  lcCtrlPkg::lcState                  modelState;
  logic [lcCtrlPkg::LcCntWidth-1:0]   modelCnt;
  int                                 errCount = 0;
  int                                 doneCount = 0;
  int                                 cycleCount = 0;

  lcCtrlTop dut0 (
    .clk_i         (clk),
    .rst_i         (rst),
    .transCmd_i    (transCmd),
    .transTarget_i (transTarget),
    .transToken_i  (transToken),
    .lcState_o     (lcState),
    .lcCnt_o       (lcCnt),
    .busy_o        (busy),
    .done_o        (done),
    .error_o       (lcError)
  );

  bind lcCtrlTop lcCtrl_assert assert0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .transCmd_i (transCmd_i),
    .busy_i     (busy_o),
    .done_i     (done_o),
    .error_i    (error_o),
    .lcState_i  (lcState_o),
    .lcCnt_i    (lcCnt_o),
    .fsmState_i (fsm0.stateQ)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Every completion is counted so that ignored strobes can be told apart
  always @(posedge clk) begin
    if (!rst && done) begin
      doneCount <= doneCount + 1;
    end
  end

  initial begin : watchdog
    while (cycleCount < MaxCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("ERROR: timeout after %0d cycles, %0d mismatches so far", MaxCycles, errCount);
    $display("test failed");
    $finish;
  end

  // --------------------
  // Reference rules
  // --------------------

  // Which token an edge has to present, zero when none is asked for
  function automatic logic [31:0] tokenFor(input lcCtrlPkg::lcState state,
                                           input lcCtrlPkg::lcState target);
    if (target == lcCtrlPkg::Scrap) return 32'h0;
    if (state == lcCtrlPkg::Raw && target == lcCtrlPkg::TestUnlocked0) begin
      return lcCtrlPkg::RawUnlockToken;
    end
    if (target inside {lcCtrlPkg::TestUnlocked0, lcCtrlPkg::TestUnlocked1,
                       lcCtrlPkg::TestUnlocked2, lcCtrlPkg::TestUnlocked3}) begin
      return lcCtrlPkg::TestUnlockToken;
    end
    if (target == lcCtrlPkg::Rma) return lcCtrlPkg::RmaToken;
    return 32'h0;
  endfunction

  task automatic predict(input lcCtrlPkg::lcState target, input logic [31:0] token,
                         output lcCtrlPkg::lcState expState,
                         output logic [lcCtrlPkg::LcCntWidth-1:0] expCnt,
                         output lcCtrlPkg::lcErr expErr);
    bit legal;
    expState = modelState;
    expCnt   = modelCnt;
    expErr   = lcCtrlPkg::ErrNone;
    if (target == lcCtrlPkg::Scrap) begin
      // Scrap wins over everything and pins the counter
      expState = lcCtrlPkg::Scrap;
      expCnt   = lcCtrlPkg::LcCntMax;
    end else if (modelCnt == lcCtrlPkg::LcCntMax) begin
      expErr = lcCtrlPkg::ErrCntOverflow;
    end else begin
      // Every other attempt costs one count, pass or fail
      expCnt = modelCnt + 1'b1;
      if (modelState == lcCtrlPkg::Raw) begin
        legal = (target == lcCtrlPkg::TestUnlocked0);
      end else if (modelState inside {lcCtrlPkg::ProdEnd, lcCtrlPkg::Rma, lcCtrlPkg::Scrap}) begin
        legal = 1'b0;
      end else begin
        legal = (target > modelState);
      end
      if (!legal) begin
        expErr = lcCtrlPkg::ErrTransInvalid;
      end else if (tokenFor(modelState, target) != 32'h0 &&
                   token != tokenFor(modelState, target)) begin
        expErr = lcCtrlPkg::ErrToken;
      end else begin
        expState = target;
      end
    end
  endtask

  // --------------------
  // Stimulus helpers
  // --------------------

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic resetDut();
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    modelState = lcCtrlPkg::Raw;
    modelCnt   = '0;
  endtask

  // Issues one request from Idle and checks the outcome at done_o
  task automatic request(input lcCtrlPkg::lcState target, input logic [31:0] token,
                         input bit strobeWhileBusy);
    lcCtrlPkg::lcState                 expState;
    logic [lcCtrlPkg::LcCntWidth-1:0]  expCnt;
    lcCtrlPkg::lcErr                   expErr;
    int                                doneBefore;
    predict(target, token, expState, expCnt, expErr);
    doneBefore  = doneCount;
    transCmd    = 1'b1;
    transTarget = target;
    transToken  = token;
    @(posedge clk);
    #1;
    transCmd   = 1'b0;
    transToken = $urandom();
    if (strobeWhileBusy) begin
      // A Scrap request in the middle must leave no trace
      @(posedge clk);
      #1;
      transCmd    = 1'b1;
      transTarget = lcCtrlPkg::Scrap;
      @(posedge clk);
      #1;
      transCmd = 1'b0;
    end
    while (!done) begin
      @(posedge clk);
      #1;
    end
    checkField("lcState_o", 32'(lcState), 32'(expState));
    checkField("lcCnt_o", 32'(lcCnt), 32'(expCnt));
    checkField("error_o", 32'(lcError), 32'(expErr));
    modelState = expState;
    modelCnt   = expCnt;
    @(posedge clk);
    #1;
    if (strobeWhileBusy) begin
      repeat (ReqCycles) @(posedge clk);
      #1;
    end
    if (doneCount != doneBefore + 1) begin
      $display("ERROR: request to %s completed %0d times instead of once",
               target.name(), doneCount - doneBefore);
      errCount++;
    end
  endtask

  task automatic randomRequest();
    lcCtrlPkg::lcState target;
    logic [31:0]       token;
    target = lcCtrlPkg::lcState'(4'($urandom_range(12, 0)));
    token  = tokenFor(modelState, target);
    // About one request in four presents a damaged token
    if ($urandom_range(3, 0) == 0) begin
      token = token ^ ($urandom() | 32'h1);
    end
    request(target, token, 1'b0);
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin : stimulus
    rst         = 1'b1;
    transCmd    = 1'b0;
    transTarget = lcCtrlPkg::Raw;
    transToken  = '0;
    modelState  = lcCtrlPkg::Raw;
    modelCnt    = '0;
    void'($urandom(Seed));
    resetDut();

    // Directed walk from Raw through every error class up to overflow
    request(lcCtrlPkg::Dev, 32'h0, 1'b0);
    request(lcCtrlPkg::TestUnlocked0, lcCtrlPkg::RawUnlockToken ^ 32'h0000_0100, 1'b0);
    request(lcCtrlPkg::TestUnlocked0, lcCtrlPkg::RawUnlockToken, 1'b0);
    request(lcCtrlPkg::TestLocked0, 32'h0, 1'b0);
    request(lcCtrlPkg::TestUnlocked1, lcCtrlPkg::RmaToken, 1'b0);
    request(lcCtrlPkg::TestUnlocked1, lcCtrlPkg::TestUnlockToken, 1'b0);
    request(lcCtrlPkg::TestLocked0, 32'h0, 1'b0);
    request(lcCtrlPkg::Dev, 32'h0, 1'b1);
    request(lcCtrlPkg::Prod, 32'h0, 1'b0);
    request(lcCtrlPkg::Dev, 32'h0, 1'b0);
    request(lcCtrlPkg::Rma, lcCtrlPkg::TestUnlockToken, 1'b0);
    request(lcCtrlPkg::Rma, lcCtrlPkg::RmaToken, 1'b0);
    // Rma is terminal, so these only burn counts until the counter tops out
    request(lcCtrlPkg::Prod, 32'h0, 1'b0);
    request(lcCtrlPkg::ProdEnd, 32'h0, 1'b0);
    request(lcCtrlPkg::Dev, 32'h0, 1'b0);
    request(lcCtrlPkg::Prod, 32'h0, 1'b0);
    request(lcCtrlPkg::Scrap, 32'h0, 1'b0);
    request(lcCtrlPkg::Dev, 32'h0, 1'b0);

    // Fresh device, random targets and tokens
    resetDut();
    for (int i = 0; i < RandomRequests; i++) begin
      randomRequest();
    end

    // Scrap from a barely used counter has to jump straight to the top
    resetDut();
    request(lcCtrlPkg::TestUnlocked0, lcCtrlPkg::RawUnlockToken, 1'b0);
    request(lcCtrlPkg::Scrap, $urandom(), 1'b0);
    request(lcCtrlPkg::Prod, 32'h0, 1'b0);

    repeat (4) @(posedge clk);
    $display("Errors: %0d model mismatches, %0d assertion failures",
             errCount, dut0.assert0.failCount);
    if (errCount == 0 && dut0.assert0.failCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: src.f
hdl/lcCtrlPkg.sv
hdl/lcStateTransition.sv
hdl/lcCtrlFsm.sv
hdl/lcProgTimer.sv
hdl/lcStateStore.sv
hdl/lcTokenCheck.sv
hdl/lcCtrlTop.sv
testbench/lcCtrl_assert.sv
testbench/lcCtrlTb.sv

// File: run.sh
#!/bin/sh
# Build and run the life cycle controller testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f src.f --top-module lcCtrlTb
status=0
./obj_dir/VlcCtrlTb +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "test failed" sim.log; then
  exit 1
fi
exit "$status"
